// File: common/mem_types_pkg.sv
package mem_types_pkg;

    // data and address width
    localparam int XLEN = 32;

    // ram depth in words
    localparam int RAM_WORDS = 256;

    // word index bits that actually select a ram row
    localparam int RAM_INDEX_BITS = $clog2(RAM_WORDS);

    // access size of a processor request
    typedef enum logic [1:0] {
        SIZE_B,  // byte
        SIZE_H,  // half word
        SIZE_W   // word
    } access_size_e;

    // fault kind returned with a memory response
    typedef enum logic {
        FAULT_NONE,
        FAULT_ACCESS  // address beyond the ram
    } fault_e;

endpackage

// File: common/misalign_pkg.sv
package misalign_pkg;

    // bytes per word and byte offset width
    localparam int LANES       = 4;
    localparam int OFFSET_BITS = 2;

    // highest byte offset inside a word
    localparam logic [OFFSET_BITS-1:0] LAST_OFFSET = OFFSET_BITS'(LANES - 1);

    // sequencing states of the misalign controller
    typedef enum logic [3:0] {
        IDLE,
        LOAD_REQ,     // read of the low word
        LOAD_WAIT,
        LOAD_REQ2,    // read of the high word
        LOAD_WAIT2,
        MERGE,        // lane merge results are registered here
        LOAD_DONE,
        STORE_CHECK,
        STORE_REQ,
        STORE_WAIT,
        STORE_REQ2,
        STORE_WAIT2,
        FAULT
    } misalign_state_e;

endpackage

// File: misalign/lane_merge.sv
module lane_merge (
    input  logic [misalign_pkg::OFFSET_BITS-1:0] lane_offset,
    input  mem_types_pkg::access_size_e          lane_size,
    input  logic [mem_types_pkg::XLEN-1:0]       lane_wdata,
    input  logic [mem_types_pkg::XLEN-1:0]       read_word1,
    input  logic [mem_types_pkg::XLEN-1:0]       read_word2,
    output logic [mem_types_pkg::XLEN-1:0]       store_word1,
    output logic [mem_types_pkg::XLEN-1:0]       store_word2,
    output logic [mem_types_pkg::XLEN-1:0]       load_word
);
    import mem_types_pkg::*;
    import misalign_pkg::*;

    logic [LANES-1:0]   size_mask;    // bytes of the access, unshifted
    logic [2*LANES-1:0] store_mask;   // bytes the store covers over both words
    logic [2*XLEN-1:0]  pair_rd;      // high word above low word
    logic [2*XLEN-1:0]  pair_wd;
    logic [2*XLEN-1:0]  pair_merged;
    logic [XLEN-1:0]    load_window;
    logic [4:0]         bit_shift;

    always_comb begin
        case (lane_size)
            SIZE_B:  size_mask = LANES'(1);
            SIZE_H:  size_mask = LANES'(3);
            default: size_mask = '1;
        endcase
    end

    assign bit_shift  = {lane_offset, 3'b000};
    assign store_mask = {{LANES{1'b0}}, size_mask} << lane_offset;

    // little endian, so byte 0 of the pair is byte 0 of the low word
    assign pair_rd = {read_word2, read_word1};
    assign pair_wd = {{XLEN{1'b0}}, lane_wdata} << bit_shift;

    // store side: new bytes where the mask is set, read bytes elsewhere
    always_comb begin
        for (int i = 0; i < 2 * LANES; i++) begin
            if (store_mask[i]) begin
                pair_merged[8*i +: 8] = pair_wd[8*i +: 8];
            end else begin
                pair_merged[8*i +: 8] = pair_rd[8*i +: 8];
            end
        end
    end

    assign store_word1 = pair_merged[XLEN-1:0];
    assign store_word2 = pair_merged[2*XLEN-1:XLEN];

    // load side: bytes from the offset upward, across the word boundary
    assign load_window = XLEN'(pair_rd >> bit_shift);

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (size_mask[i]) begin
                load_word[8*i +: 8] = load_window[8*i +: 8];
            end else begin
                load_word[8*i +: 8] = 8'h00;  // zero extension
            end
        end
    end

endmodule

// File: misalign/misalign_ctrl.sv
module misalign_ctrl (
    input  logic                                 clk,
    input  logic                                 reset,
    // processor side
    input  logic                                 dreq_valid,
    output logic                                 dreq_ready,
    input  logic [mem_types_pkg::XLEN-1:0]       dreq_addr,
    input  logic                                 dreq_wen,
    input  mem_types_pkg::access_size_e          dreq_size,
    input  logic [mem_types_pkg::XLEN-1:0]       dreq_wdata,
    output logic                                 dresp_valid,
    output logic                                 dresp_error,
    output mem_types_pkg::fault_e                dresp_fault,
    output logic [mem_types_pkg::XLEN-1:0]       dresp_rdata,
    // memory side
    output logic                                 mem_req_valid,
    input  logic                                 mem_req_ready,
    output logic [mem_types_pkg::XLEN-1:0]       mem_req_addr,
    output logic                                 mem_req_wen,
    output logic [mem_types_pkg::XLEN-1:0]       mem_req_wdata,
    input  logic                                 mem_resp_valid,
    input  logic                                 mem_resp_error,
    input  mem_types_pkg::fault_e                mem_resp_fault,
    input  logic [mem_types_pkg::XLEN-1:0]       mem_resp_rdata,
    // lane merge
    output logic [misalign_pkg::OFFSET_BITS-1:0] lane_offset,
    output mem_types_pkg::access_size_e          lane_size,
    output logic [mem_types_pkg::XLEN-1:0]       lane_wdata,
    output logic [mem_types_pkg::XLEN-1:0]       read_word1,
    output logic [mem_types_pkg::XLEN-1:0]       read_word2,
    input  logic [mem_types_pkg::XLEN-1:0]       store_word1,
    input  logic [mem_types_pkg::XLEN-1:0]       store_word2,
    input  logic [mem_types_pkg::XLEN-1:0]       load_word
);
    import mem_types_pkg::*;
    import misalign_pkg::*;

    misalign_state_e state;

    // registered request
    logic [XLEN-1:0]        req_addr;
    logic                   req_wen;
    access_size_e           req_size;
    logic [XLEN-1:0]        req_wdata;

    logic [OFFSET_BITS-1:0] req_offset;
    logic [XLEN-1:0]        word_addr;
    logic                   two_words;
    logic                   need_read;
    logic                   accept;

    // merge results and response capture
    logic [XLEN-1:0]        store_data1;
    logic [XLEN-1:0]        store_data2;
    logic [XLEN-1:0]        load_result;
    logic                   resp_error;
    fault_e                 resp_fault;

    assign accept     = dreq_valid && dreq_ready;
    assign req_offset = req_addr[OFFSET_BITS-1:0];
    assign word_addr  = {req_addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // crosses into the next word
    assign two_words = (req_size == SIZE_W && req_offset != '0) ||
                       (req_size == SIZE_H && req_offset == LAST_OFFSET);
    // only an aligned word store can write without reading first
    assign need_read = !(req_size == SIZE_W && req_offset == '0);

    assign dreq_ready = (state == IDLE);

    assign mem_req_valid = (state == LOAD_REQ) || (state == LOAD_REQ2) ||
                           (state == STORE_REQ) || (state == STORE_REQ2);
    assign mem_req_wen   = (state == STORE_REQ) || (state == STORE_REQ2);
    assign mem_req_addr  = (state == LOAD_REQ2 || state == STORE_REQ2) ?
                           word_addr + XLEN'(LANES) : word_addr;
    assign mem_req_wdata = (state == STORE_REQ2) ? store_data2 : store_data1;

    // store completion is signalled straight off the write response
    assign dresp_valid = (state == LOAD_DONE) || (state == FAULT) ||
                         (state == STORE_WAIT && mem_resp_valid && !mem_resp_error &&
                          !two_words) ||
                         (state == STORE_WAIT2 && mem_resp_valid && !mem_resp_error);
    assign dresp_error = resp_error;
    assign dresp_fault = resp_fault;
    assign dresp_rdata = load_result;

    assign lane_offset = req_offset;
    assign lane_size   = req_size;
    assign lane_wdata  = req_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            resp_error <= 1'b0;
            resp_fault <= FAULT_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        resp_error <= 1'b0;  // fresh status per access
                        resp_fault <= FAULT_NONE;
                        if (dreq_wen) begin
                            state <= STORE_CHECK;
                        end else begin
                            state <= LOAD_REQ;
                        end
                    end
                end
                STORE_CHECK: begin
                    if (need_read) begin
                        state <= LOAD_REQ;
                    end else begin
                        state <= MERGE;  // merge passes the whole word through
                    end
                end
                LOAD_REQ:   if (mem_req_ready) state <= LOAD_WAIT;
                LOAD_REQ2:  if (mem_req_ready) state <= LOAD_WAIT2;
                STORE_REQ:  if (mem_req_ready) state <= STORE_WAIT;
                STORE_REQ2: if (mem_req_ready) state <= STORE_WAIT2;
                LOAD_WAIT, LOAD_WAIT2, STORE_WAIT, STORE_WAIT2: begin
                    if (mem_resp_valid) begin
                        if (mem_resp_error) begin
                            resp_error <= 1'b1;
                            resp_fault <= mem_resp_fault;
                            state      <= FAULT;  // no further transfers
                        end else if (state == LOAD_WAIT && two_words) begin
                            state <= LOAD_REQ2;
                        end else if (state == LOAD_WAIT || state == LOAD_WAIT2) begin
                            state <= MERGE;
                        end else if (state == STORE_WAIT && two_words) begin
                            state <= STORE_REQ2;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                MERGE: begin
                    if (req_wen) begin
                        state <= STORE_REQ;
                    end else begin
                        state <= LOAD_DONE;
                    end
                end
                LOAD_DONE: state <= IDLE;
                FAULT:     state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= dreq_addr;
            req_wen   <= dreq_wen;
            req_size  <= dreq_size;
            req_wdata <= dreq_wdata;
        end
        if (state == LOAD_WAIT && mem_resp_valid) begin
            read_word1 <= mem_resp_rdata;
        end
        if (state == LOAD_WAIT2 && mem_resp_valid) begin
            read_word2 <= mem_resp_rdata;
        end
        if (state == MERGE) begin
            store_data1 <= store_word1;
            store_data2 <= store_word2;
            load_result <= load_word;
        end
    end

endmodule

// File: design/data_ram.sv
module data_ram (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           mem_req_valid,
    output logic                           mem_req_ready,
    input  logic [mem_types_pkg::XLEN-1:0] mem_req_addr,
    input  logic                           mem_req_wen,
    input  logic [mem_types_pkg::XLEN-1:0] mem_req_wdata,
    output logic                           mem_resp_valid,
    output logic                           mem_resp_error,
    output mem_types_pkg::fault_e          mem_resp_fault,
    output logic [mem_types_pkg::XLEN-1:0] mem_resp_rdata
);
    import mem_types_pkg::*;

    logic [XLEN-1:0]           mem [RAM_WORDS];

    logic [XLEN-3:0]           word_index;
    logic [RAM_INDEX_BITS-1:0] row;
    logic                      in_range;
    logic                      accept;

    // two stage response pipe
    logic                      s1_valid;
    logic                      s1_error;
    logic [XLEN-1:0]           s1_rdata;
    logic                      s2_valid;
    logic                      s2_error;
    logic [XLEN-1:0]           s2_rdata;

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign word_index = mem_req_addr[XLEN-1:2];
    assign row        = word_index[RAM_INDEX_BITS-1:0];
    assign in_range   = (word_index < RAM_WORDS);
    assign accept     = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req_ready <= 1'b0;
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
        end else begin
            mem_req_ready <= !accept;  // back up in the response cycle
            s1_valid      <= accept;
            s2_valid      <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem_req_wen && in_range) begin
            mem[row] <= mem_req_wdata;
        end
        s1_error <= !in_range;
        s1_rdata <= in_range ? mem[row] : '0;
        s2_error <= s1_error;
        s2_rdata <= s1_rdata;
    end

    assign mem_resp_valid = s2_valid;
    assign mem_resp_error = s2_error;
    assign mem_resp_fault = s2_error ? FAULT_ACCESS : FAULT_NONE;
    assign mem_resp_rdata = s2_rdata;

endmodule

// File: design/dmem_top.sv
module dmem_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           dreq_valid,
    output logic                           dreq_ready,
    input  logic [mem_types_pkg::XLEN-1:0] dreq_addr,
    input  logic                           dreq_wen,
    input  mem_types_pkg::access_size_e    dreq_size,
    input  logic [mem_types_pkg::XLEN-1:0] dreq_wdata,
    output logic                           dresp_valid,
    output logic                           dresp_error,
    output mem_types_pkg::fault_e          dresp_fault,
    output logic [mem_types_pkg::XLEN-1:0] dresp_rdata
);
    import mem_types_pkg::*;
    import misalign_pkg::*;

    // controller to ram
    logic                   mem_req_valid;
    logic                   mem_req_ready;
    logic [XLEN-1:0]        mem_req_addr;
    logic                   mem_req_wen;
    logic [XLEN-1:0]        mem_req_wdata;
    logic                   mem_resp_valid;
    logic                   mem_resp_error;
    fault_e                 mem_resp_fault;
    logic [XLEN-1:0]        mem_resp_rdata;

    // controller to lane merge
    logic [OFFSET_BITS-1:0] lane_offset;
    access_size_e           lane_size;
    logic [XLEN-1:0]        lane_wdata;
    logic [XLEN-1:0]        read_word1;
    logic [XLEN-1:0]        read_word2;
    logic [XLEN-1:0]        store_word1;
    logic [XLEN-1:0]        store_word2;
    logic [XLEN-1:0]        load_word;

    misalign_ctrl i_misalign_ctrl (.*);

    lane_merge i_lane_merge (.*);

    data_ram i_data_ram (.*);

endmodule

// File: dv/dmem_tb.sv
module dmem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_types_pkg::*;
    import misalign_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_ACC = 40;
    localparam int RANDOM_COUNT   = 24;
    localparam logic [XLEN-1:0] END_ADDR  = XLEN'(RAM_WORDS * LANES);  // first byte past ram
    localparam logic [XLEN-1:0] LAST_WORD = END_ADDR - XLEN'(LANES);

    typedef struct packed {
        logic            wen;
        access_size_e    size;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            exp_fault;
    } access_entry_t;

    logic            clk;
    logic            reset;
    logic            dreq_valid;
    logic            dreq_ready;
    logic [XLEN-1:0] dreq_addr;
    logic            dreq_wen;
    access_size_e    dreq_size;
    logic [XLEN-1:0] dreq_wdata;
    logic            dresp_valid;
    logic            dresp_error;
    fault_e          dresp_fault;
    logic [XLEN-1:0] dresp_rdata;

    access_entry_t   access_table[$];
    logic [7:0]      model_mem [RAM_WORDS * LANES];  // little-endian byte image
    logic            table_built;
    int              error_count;
    int              check_count;

    dmem_top i_dmem_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int access_bytes(input access_size_e size);
        case (size)
            SIZE_B:  return 1;
            SIZE_H:  return 2;
            default: return 4;
        endcase
    endfunction

    function automatic string size_text(input access_size_e size);
        case (size)
            SIZE_B:  return "byte";
            SIZE_H:  return "half";
            default: return "word";
        endcase
    endfunction

    task automatic add_access(input logic wen, input access_size_e size,
                              input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                              input logic exp_fault);
        access_entry_t entry;
        entry.wen       = wen;
        entry.size      = size;
        entry.addr      = addr;
        entry.wdata     = wdata;
        entry.exp_fault = exp_fault;
        access_table.push_back(entry);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // zero-extended load value from the byte image
    function automatic logic [XLEN-1:0] model_load(input logic [XLEN-1:0] addr,
                                                   input access_size_e size);
        logic [XLEN-1:0] value;
        value = '0;
        for (int i = 0; i < access_bytes(size); i++) begin
            value[8*i +: 8] = model_mem[int'(addr) + i];
        end
        return value;
    endfunction

    task automatic model_store(input logic [XLEN-1:0] addr, input access_size_e size,
                               input logic [XLEN-1:0] wdata);
        for (int i = 0; i < access_bytes(size); i++) begin
            model_mem[int'(addr) + i] = wdata[8*i +: 8];
        end
    endtask

    task automatic build_table();
        int pick;
        logic [XLEN-1:0] rand_word;
        // aligned words, then loads of every size and offset
        add_access(1, SIZE_W, 32'h00, 32'h11223344, 0);
        add_access(1, SIZE_W, 32'h04, 32'h55667788, 0);
        add_access(0, SIZE_W, 32'h00, '0, 0);
        add_access(0, SIZE_W, 32'h04, '0, 0);
        for (int off = 0; off < LANES; off++) begin
            add_access(0, SIZE_B, XLEN'(off), '0, 0);
            add_access(0, SIZE_H, XLEN'(off), '0, 0);  // offset 3 spans two words
        end
        for (int off = 1; off < LANES; off++) begin
            add_access(0, SIZE_W, XLEN'(off), '0, 0);
        end
        // partial stores into known neighbors
        add_access(1, SIZE_W, 32'h08, 32'ha0a1a2a3, 0);
        add_access(1, SIZE_W, 32'h0c, 32'hb0b1b2b3, 0);
        add_access(1, SIZE_W, 32'h10, 32'hc0c1c2c3, 0);
        add_access(1, SIZE_W, 32'h14, 32'hd0d1d2d3, 0);
        add_access(1, SIZE_W, 32'h18, 32'he0e1e2e3, 0);
        add_access(1, SIZE_B, 32'h09, 32'h0000005a, 0);
        add_access(1, SIZE_H, 32'h0e, 32'h00006b7c, 0);
        add_access(1, SIZE_W, 32'h11, 32'h8d9eafb0, 0);
        add_access(1, SIZE_H, 32'h17, 32'h0000c1d2, 0);
        for (int w = 2; w <= 6; w++) begin
            add_access(0, SIZE_W, XLEN'(w * LANES), '0, 0);
        end
        // out of range accesses
        add_access(0, SIZE_W, END_ADDR, '0, 1);
        add_access(1, SIZE_B, END_ADDR + 2, 32'h000000ee, 1);
        add_access(1, SIZE_W, LAST_WORD, 32'h13579bdf, 0);
        add_access(1, SIZE_W, LAST_WORD + 2, 32'hfeedf00d, 1);  // second word beyond ram
        add_access(0, SIZE_W, LAST_WORD, '0, 0);
        add_access(0, SIZE_W, LAST_WORD + 1, '0, 1);
        add_access(0, SIZE_H, LAST_WORD + 3, '0, 1);
        // random traffic kept inside the first 16 words
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            pick      = $urandom % 3;
            rand_word = $urandom;
            add_access(1'($urandom % 2), (pick == 0) ? SIZE_B : (pick == 1) ? SIZE_H : SIZE_W,
                       XLEN'(($urandom % 16) * LANES + ($urandom % LANES)), rand_word, 0);
        end
    endtask

    task automatic run_access(input int idx);
        access_entry_t entry;
        int errors_before;
        entry         = access_table[idx];
        errors_before = error_count;
        while (!dreq_ready) @(negedge clk);
        dreq_valid = 1'b1;
        dreq_addr  = entry.addr;
        dreq_wen   = entry.wen;
        dreq_size  = entry.size;
        dreq_wdata = entry.wdata;
        @(negedge clk);  // taken on the rising edge just passed
        dreq_valid = 1'b0;
        check_value("dreq_ready", '0, XLEN'(dreq_ready));  // busy once the request is taken
        while (!dresp_valid) @(negedge clk);
        check_value("dresp_error", XLEN'(entry.exp_fault), XLEN'(dresp_error));
        check_value("dresp_fault", entry.exp_fault ? XLEN'(FAULT_ACCESS) : XLEN'(FAULT_NONE),
                    XLEN'(dresp_fault));
        if (!entry.exp_fault) begin
            if (entry.wen) begin
                model_store(entry.addr, entry.size, entry.wdata);
            end else begin
                check_value("dresp_rdata", model_load(entry.addr, entry.size), dresp_rdata);
            end
        end
        @(negedge clk);
        check_value("dresp_valid", '0, XLEN'(dresp_valid));  // single cycle pulse
        $display("entry %0d: %s %s addr %h fault %0b -> %s", idx,
                 entry.wen ? "store" : "load", size_text(entry.size), entry.addr,
                 entry.exp_fault, (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_wen    = 1'b0;
        dreq_size   = SIZE_B;
        dreq_wdata  = '0;
        table_built = 1'b0;
        error_count = 0;
        check_count = 0;
        void'($urandom(32'h12c0));
        for (int i = 0; i < RAM_WORDS * LANES; i++) begin
            model_mem[i] = 8'h00;  // ram powers up cleared
        end
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < access_table.size(); i++) begin
            run_access(i);
        end
        $display("entries %0d, checks %0d, errors %0d", access_table.size(), check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog scaled to the table length
    initial begin
        int timeout_ns;
        wait (table_built);
        timeout_ns = (access_table.size() * CYCLES_PER_ACC + 2 * RESET_CYCLES) * CLK_PERIOD;
        #(timeout_ns);
        $display("timeout: the DUT did not finish all accesses within %0d ns", timeout_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: project.f
common/mem_types_pkg.sv
common/misalign_pkg.sv
misalign/lane_merge.sv
misalign/misalign_ctrl.sv
design/data_ram.sv
design/dmem_top.sv
dv/dmem_tb.sv
